/* rtl/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// machine word, also the address width of both buses
`define MIPS_XLEN 32

`define MIPS_NREGS 32
`define MIPS_RADDR_W 5

`define MIPS_RESET_PC 32'h0000_0000 // first fetch address

`endif

/* rtl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of the SPECIAL opcode
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_view_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_view_t;

    // one instruction word, read as register or immediate format
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } inst_t;

endpackage

`default_nettype wire

/* rtl/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    // where a decode operand is taken from
    typedef enum logic [1:0] {
        FWD_REGFILE,
        FWD_FROM_EX,
        FWD_FROM_MM,
        FWD_FROM_WB
    } fwd_sel_e;

endpackage

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_cfg.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en_i,
    input  logic                  branch_taken_i,
    input  logic [`MIPS_XLEN-1:0] branch_target_i,
    input  logic                  ibus_stall_i,
    output logic [`MIPS_XLEN-1:0] ibus_addr_o,
    output logic                  ibus_read_o,
    output logic [`MIPS_XLEN-1:0] pc_o
);

    logic [`MIPS_XLEN-1:0] pc_q;
    logic [`MIPS_XLEN-1:0] hold_addr_q;
    logic                  hold_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= `MIPS_RESET_PC;
        end else if (en_i) begin
            pc_q <= branch_taken_i ? branch_target_i : pc_q + `MIPS_XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q <= 1'b0;
        end else begin
            hold_q <= ibus_read_o & ibus_stall_i; // read still pending next cycle
        end
    end

    // latch the address on the first cycle of each read
    always_ff @(posedge clk) begin
        if (!hold_q && ibus_read_o) begin
            hold_addr_q <= pc_q;
        end
    end

    assign ibus_read_o = 1'b1; // fetch reads every cycle
    assign ibus_addr_o = hold_q ? hold_addr_q : pc_q;
    assign pc_o        = pc_q;

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_cfg.svh"

module reg_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`MIPS_RADDR_W-1:0] raddr_a_i,
    input  logic [`MIPS_RADDR_W-1:0] raddr_b_i,
    output logic [`MIPS_XLEN-1:0]    rdata_a_o,
    output logic [`MIPS_XLEN-1:0]    rdata_b_o,
    input  logic                     we_i,
    input  logic [`MIPS_RADDR_W-1:0] waddr_i,
    input  logic [`MIPS_XLEN-1:0]    wdata_i
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

    // writes are ignored while in reset
    always_ff @(posedge clk) begin
        if (rst_n && we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

/* rtl/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_cfg.svh"

module decode_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     en_i,
    input  logic                     bubble_i,
    input  logic [`MIPS_XLEN-1:0]    pc_i,
    input  logic [`MIPS_XLEN-1:0]    ibus_rdata_i,
    input  logic [`MIPS_XLEN-1:0]    fwd_a_i,
    input  logic [`MIPS_XLEN-1:0]    fwd_b_i,
    output logic [`MIPS_RADDR_W-1:0] rs_o,
    output logic [`MIPS_RADDR_W-1:0] rt_o,
    output logic [`MIPS_RADDR_W-1:0] dest_o,
    output pipe_pkg::alu_op_e        alu_op_o,
    output pipe_pkg::mem_op_e        mem_op_o,
    output logic [`MIPS_XLEN-1:0]    operand_a_o,
    output logic [`MIPS_XLEN-1:0]    operand_b_o,
    output logic [`MIPS_XLEN-1:0]    store_data_o,
    output logic                     branch_taken_o,
    output logic [`MIPS_XLEN-1:0]    branch_target_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    inst_t                 inst_q;
    logic [`MIPS_XLEN-1:0] pc_q;
    logic [`MIPS_XLEN-1:0] imm_ext;
    logic                  use_imm;
    logic                  zero_ext;
    logic                  operands_eq;

    always_ff @(posedge clk) begin
        if (!rst_n || bubble_i) begin
            inst_q <= '0; // sll r0,r0,0 which decodes as a no-op
            pc_q   <= '0;
        end else if (en_i) begin
            inst_q <= ibus_rdata_i;
            pc_q   <= pc_i;
        end
    end

    // rs and rt sit at the same bits in both views
    assign rs_o = inst_q.r.rs;
    assign rt_o = inst_q.r.rt;

    assign zero_ext = inst_q.i.opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    assign imm_ext  = zero_ext ? {{(`MIPS_XLEN-16){1'b0}}, inst_q.i.imm}
                               : {{(`MIPS_XLEN-16){inst_q.i.imm[15]}}, inst_q.i.imm};

    always_comb begin
        alu_op_o = ALU_ADD;
        mem_op_o = MEM_NONE;
        dest_o   = '0;
        use_imm  = 1'b0;
        case (inst_q.i.opcode)
            OP_SPECIAL: begin
                dest_o = inst_q.r.rd;
                case (inst_q.r.funct)
                    FN_ADDU: alu_op_o = ALU_ADD;
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_XOR:  alu_op_o = ALU_XOR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    FN_SLTU: alu_op_o = ALU_SLTU;
                    default: dest_o = '0; // unknown funct, nothing written
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
                dest_o  = inst_q.i.rt;
                use_imm = 1'b1;
            end
            OP_SW:   use_imm = 1'b1;
            default: ;
        endcase
        case (inst_q.i.opcode)
            OP_SLTI: alu_op_o = ALU_SLT;
            OP_ANDI: alu_op_o = ALU_AND;
            OP_ORI:  alu_op_o = ALU_OR;
            OP_XORI: alu_op_o = ALU_XOR;
            OP_LUI:  alu_op_o = ALU_LUI;
            OP_LW:   mem_op_o = MEM_LOAD;
            OP_SW:   mem_op_o = MEM_STORE;
            default: ;
        endcase
    end

    assign operand_a_o  = fwd_a_i;
    assign operand_b_o  = use_imm ? imm_ext : fwd_b_i;
    assign store_data_o = fwd_b_i;

    // branches resolve here, target is relative to the delay slot
    assign operands_eq     = (fwd_a_i == fwd_b_i);
    assign branch_taken_o  = (inst_q.i.opcode == OP_BEQ &&  operands_eq) ||
                             (inst_q.i.opcode == OP_BNE && !operands_eq);
    assign branch_target_o = pc_q + `MIPS_XLEN'(4) + {imm_ext[`MIPS_XLEN-3:0], 2'b00};

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_cfg.svh"

module hazard_unit (
    input  logic [`MIPS_RADDR_W-1:0] rs_i,
    input  logic [`MIPS_RADDR_W-1:0] rt_i,
    input  logic [`MIPS_RADDR_W-1:0] ex_dest_i,
    input  pipe_pkg::mem_op_e        ex_mem_op_i,
    input  logic [`MIPS_RADDR_W-1:0] mm_dest_i,
    input  pipe_pkg::mem_op_e        mm_mem_op_i,
    input  logic [`MIPS_RADDR_W-1:0] wb_dest_i,
    input  logic                     wb_we_i,
    input  logic                     ibus_stall_i,
    input  logic                     dbus_stall_i,
    output pipe_pkg::fwd_sel_e       fwd_a_o,
    output pipe_pkg::fwd_sel_e       fwd_b_o,
    output logic                     en_pc_o,
    output logic                     en_ifid_o,
    output logic                     en_idex_o,
    output logic                     en_exmm_o,
    output logic                     en_mmwb_o
);

    import pipe_pkg::*;

    logic       ex_load_hit;
    logic       mm_load_hit;
    logic [4:0] en; // pc, ifid, idex, exmm, mmwb

    // youngest producer wins, non-writers carry dest zero
    function automatic fwd_sel_e pick_src(input logic [`MIPS_RADDR_W-1:0] src);
        return (src == '0)                   ? FWD_REGFILE :
               (src == ex_dest_i)            ? FWD_FROM_EX :
               (src == mm_dest_i)            ? FWD_FROM_MM :
               (wb_we_i && src == wb_dest_i) ? FWD_FROM_WB : FWD_REGFILE;
    endfunction

    assign ex_load_hit = ex_mem_op_i == MEM_LOAD && ex_dest_i != '0 &&
                         (ex_dest_i == rs_i || ex_dest_i == rt_i);
    assign mm_load_hit = mm_mem_op_i == MEM_LOAD && mm_dest_i != '0 &&
                         (mm_dest_i == rs_i || mm_dest_i == rt_i);

    always_comb begin
        fwd_a_o = pick_src(rs_i);
        fwd_b_o = pick_src(rt_i);
        if (dbus_stall_i) begin
            en = 5'b00000;
        end else if (ex_load_hit || mm_load_hit || ibus_stall_i) begin
            en = 5'b00011; // hold decode, bubble into execute
        end else begin
            en = 5'b11111;
        end
    end

    assign {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o} = en;

endmodule

`default_nettype wire

/* rtl/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_cfg.svh"

module execute_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     en_i,
    input  logic                     bubble_i,
    input  logic [`MIPS_RADDR_W-1:0] dest_i,
    input  pipe_pkg::alu_op_e        alu_op_i,
    input  pipe_pkg::mem_op_e        mem_op_i,
    input  logic [`MIPS_XLEN-1:0]    operand_a_i,
    input  logic [`MIPS_XLEN-1:0]    operand_b_i,
    input  logic [`MIPS_XLEN-1:0]    store_data_i,
    output logic [`MIPS_XLEN-1:0]    result_o,
    output logic [`MIPS_RADDR_W-1:0] dest_o,
    output pipe_pkg::mem_op_e        mem_op_o,
    output logic [`MIPS_XLEN-1:0]    store_data_o
);

    import pipe_pkg::*;

    alu_op_e               alu_op_q;
    logic [`MIPS_XLEN-1:0] a_q;
    logic [`MIPS_XLEN-1:0] b_q;

    always_ff @(posedge clk) begin
        if (!rst_n || bubble_i) begin
            alu_op_q <= ALU_ADD;
            mem_op_o <= MEM_NONE;
            dest_o   <= '0;
        end else if (en_i) begin
            alu_op_q <= alu_op_i;
            mem_op_o <= mem_op_i;
            dest_o   <= dest_i;
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            a_q          <= operand_a_i;
            b_q          <= operand_b_i;
            store_data_o <= store_data_i;
        end
    end

    // also the execute-stage forwarding value
    always_comb begin
        case (alu_op_q)
            ALU_ADD:  result_o = a_q + b_q;
            ALU_SUB:  result_o = a_q - b_q;
            ALU_AND:  result_o = a_q & b_q;
            ALU_OR:   result_o = a_q | b_q;
            ALU_XOR:  result_o = a_q ^ b_q;
            ALU_SLT:  result_o = `MIPS_XLEN'($signed(a_q) < $signed(b_q));
            ALU_SLTU: result_o = `MIPS_XLEN'(a_q < b_q);
            ALU_LUI:  result_o = {b_q[15:0], {(`MIPS_XLEN-16){1'b0}}};
            default:  result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/mem_wb_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_cfg.svh"

module mem_wb_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     en_exmm_i,
    input  logic                     en_mmwb_i,
    input  logic [`MIPS_XLEN-1:0]    ex_result_i,
    input  logic [`MIPS_RADDR_W-1:0] ex_dest_i,
    input  pipe_pkg::mem_op_e        ex_mem_op_i,
    input  logic [`MIPS_XLEN-1:0]    ex_store_data_i,
    output logic [`MIPS_XLEN-1:0]    dbus_addr_o,
    output logic                     dbus_read_o,
    output logic                     dbus_write_o,
    output logic [`MIPS_XLEN-1:0]    dbus_wdata_o,
    input  logic [`MIPS_XLEN-1:0]    dbus_rdata_i,
    output logic [`MIPS_XLEN-1:0]    mm_result_o,
    output logic [`MIPS_RADDR_W-1:0] mm_dest_o,
    output pipe_pkg::mem_op_e        mm_mem_op_o,
    output logic                     wb_we_o,
    output logic [`MIPS_RADDR_W-1:0] wb_dest_o,
    output logic [`MIPS_XLEN-1:0]    wb_data_o
);

    import pipe_pkg::*;

    logic [`MIPS_XLEN-1:0] store_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mm_dest_o   <= '0;
            mm_mem_op_o <= MEM_NONE;
        end else if (en_exmm_i) begin
            mm_dest_o   <= ex_dest_i;
            mm_mem_op_o <= ex_mem_op_i;
        end
    end

    always_ff @(posedge clk) begin
        if (en_exmm_i) begin
            mm_result_o <= ex_result_i; // alu result or memory address
            store_q     <= ex_store_data_i;
        end
    end

    // request stays up while the bus stalls since EX/MM is frozen then
    assign dbus_addr_o  = mm_result_o;
    assign dbus_read_o  = (mm_mem_op_o == MEM_LOAD);
    assign dbus_write_o = (mm_mem_op_o == MEM_STORE);
    assign dbus_wdata_o = store_q;

    always_ff @(posedge clk) begin
        if (!rst_n || !en_mmwb_i) begin
            wb_dest_o <= '0;
        end else begin
            wb_dest_o <= mm_dest_o;
        end
    end

    always_ff @(posedge clk) begin
        if (en_mmwb_i) begin
            wb_data_o <= dbus_read_o ? dbus_rdata_i : mm_result_o;
        end
    end

    assign wb_we_o = (wb_dest_o != '0);

endmodule

`default_nettype wire

/* rtl/naive_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_cfg.svh"

module naive_core (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic [`MIPS_XLEN-1:0] ibus_addr_o,
    output logic                  ibus_read_o,
    input  logic [`MIPS_XLEN-1:0] ibus_rdata_i,
    input  logic                  ibus_stall_i,
    output logic [`MIPS_XLEN-1:0] dbus_addr_o,
    output logic                  dbus_read_o,
    output logic                  dbus_write_o,
    output logic [`MIPS_XLEN-1:0] dbus_wdata_o,
    input  logic [`MIPS_XLEN-1:0] dbus_rdata_i,
    input  logic                  dbus_stall_i
);

    import pipe_pkg::*;

    logic en_pc;
    logic en_ifid;
    logic en_idex;
    logic en_exmm;
    logic en_mmwb;

    logic [`MIPS_XLEN-1:0]    if_pc;
    logic                     branch_taken;
    logic [`MIPS_XLEN-1:0]    branch_target;

    logic [`MIPS_RADDR_W-1:0] id_rs;
    logic [`MIPS_RADDR_W-1:0] id_rt;
    logic [`MIPS_RADDR_W-1:0] id_dest;
    alu_op_e                  id_alu_op;
    mem_op_e                  id_mem_op;
    logic [`MIPS_XLEN-1:0]    id_operand_a;
    logic [`MIPS_XLEN-1:0]    id_operand_b;
    logic [`MIPS_XLEN-1:0]    id_store_data;
    logic [`MIPS_XLEN-1:0]    rf_a;
    logic [`MIPS_XLEN-1:0]    rf_b;
    logic [`MIPS_XLEN-1:0]    fwd_a;
    logic [`MIPS_XLEN-1:0]    fwd_b;
    fwd_sel_e                 fwd_a_sel;
    fwd_sel_e                 fwd_b_sel;

    logic [`MIPS_XLEN-1:0]    ex_result;
    logic [`MIPS_RADDR_W-1:0] ex_dest;
    mem_op_e                  ex_mem_op;
    logic [`MIPS_XLEN-1:0]    ex_store_data;
    logic [`MIPS_XLEN-1:0]    mm_result;
    logic [`MIPS_RADDR_W-1:0] mm_dest;
    mem_op_e                  mm_mem_op;
    logic                     wb_we;
    logic [`MIPS_RADDR_W-1:0] wb_dest;
    logic [`MIPS_XLEN-1:0]    wb_data;

    function automatic logic [`MIPS_XLEN-1:0] fwd_value(input fwd_sel_e sel,
                                                         input logic [`MIPS_XLEN-1:0] rf);
        case (sel)
            FWD_FROM_EX: return ex_result;
            FWD_FROM_MM: return mm_result;
            FWD_FROM_WB: return wb_data;
            default:     return rf;
        endcase
    endfunction

    always_comb begin
        fwd_a = fwd_value(fwd_a_sel, rf_a);
        fwd_b = fwd_value(fwd_b_sel, rf_b);
    end

    fetch_unit fetch_unit_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .en_i            (en_pc),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .ibus_stall_i    (ibus_stall_i),
        .ibus_addr_o     (ibus_addr_o),
        .ibus_read_o     (ibus_read_o),
        .pc_o            (if_pc)
    );

    reg_file reg_file_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .raddr_a_i (id_rs),
        .raddr_b_i (id_rt),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b),
        .we_i      (wb_we),
        .waddr_i   (wb_dest),
        .wdata_i   (wb_data)
    );

    decode_unit decode_unit_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .en_i            (en_ifid),
        .bubble_i        (en_idex & ~en_ifid),
        .pc_i            (if_pc),
        .ibus_rdata_i    (ibus_rdata_i),
        .fwd_a_i         (fwd_a),
        .fwd_b_i         (fwd_b),
        .rs_o            (id_rs),
        .rt_o            (id_rt),
        .dest_o          (id_dest),
        .alu_op_o        (id_alu_op),
        .mem_op_o        (id_mem_op),
        .operand_a_o     (id_operand_a),
        .operand_b_o     (id_operand_b),
        .store_data_o    (id_store_data),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    hazard_unit hazard_unit_inst (
        .rs_i         (id_rs),
        .rt_i         (id_rt),
        .ex_dest_i    (ex_dest),
        .ex_mem_op_i  (ex_mem_op),
        .mm_dest_i    (mm_dest),
        .mm_mem_op_i  (mm_mem_op),
        .wb_dest_i    (wb_dest),
        .wb_we_i      (wb_we),
        .ibus_stall_i (ibus_stall_i),
        .dbus_stall_i (dbus_stall_i),
        .fwd_a_o      (fwd_a_sel),
        .fwd_b_o      (fwd_b_sel),
        .en_pc_o      (en_pc),
        .en_ifid_o    (en_ifid),
        .en_idex_o    (en_idex),
        .en_exmm_o    (en_exmm),
        .en_mmwb_o    (en_mmwb)
    );

    execute_unit execute_unit_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .en_i         (en_idex),
        .bubble_i     (en_exmm & ~en_idex), // decode held, execute moves on
        .dest_i       (id_dest),
        .alu_op_i     (id_alu_op),
        .mem_op_i     (id_mem_op),
        .operand_a_i  (id_operand_a),
        .operand_b_i  (id_operand_b),
        .store_data_i (id_store_data),
        .result_o     (ex_result),
        .dest_o       (ex_dest),
        .mem_op_o     (ex_mem_op),
        .store_data_o (ex_store_data)
    );

    mem_wb_unit mem_wb_unit_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .en_exmm_i       (en_exmm),
        .en_mmwb_i       (en_mmwb),
        .ex_result_i     (ex_result),
        .ex_dest_i       (ex_dest),
        .ex_mem_op_i     (ex_mem_op),
        .ex_store_data_i (ex_store_data),
        .dbus_addr_o     (dbus_addr_o),
        .dbus_read_o     (dbus_read_o),
        .dbus_write_o    (dbus_write_o),
        .dbus_wdata_o    (dbus_wdata_o),
        .dbus_rdata_i    (dbus_rdata_i),
        .mm_result_o     (mm_result),
        .mm_dest_o       (mm_dest),
        .mm_mem_op_o     (mm_mem_op),
        .wb_we_o         (wb_we),
        .wb_dest_o       (wb_dest),
        .wb_data_o       (wb_data)
    );

endmodule

`default_nettype wire

/* sim/naive_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_cfg.svh"

module naive_core_tb;

    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_SLTI    = 6'h0a;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_XORI    = 6'h0e;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;
    localparam int BODY_LEN = 160;
    localparam logic [31:0] SIG_BASE = 32'h0000_2000;
    localparam logic [31:0] MARKER   = 32'h0000_3000;

    logic        clk;
    logic        rst_n;
    logic [31:0] ibus_addr;
    logic        ibus_read;
    logic [31:0] ibus_rdata;
    logic        ibus_stall;
    logic [31:0] dbus_addr;
    logic        dbus_read;
    logic        dbus_write;
    logic [31:0] dbus_wdata;
    logic [31:0] dbus_rdata;
    logic        dbus_stall;

    integer      seed;
    integer      prog_len;
    integer      cycles;
    integer      limit;
    integer      wr_idx;
    integer      ld_idx;
    logic        first_seen;
    logic        marker_seen;
    logic        ibus_hold;
    logic        dbus_hold;
    logic [31:0] prev_iaddr;
    logic [31:0] prev_daddr;
    logic [31:0] prev_dwdata;
    logic        prev_dread;
    logic        prev_dwrite;

    logic [31:0] imem [1024];
    logic [31:0] dmem [4096];
    logic [31:0] model_dmem [4096];
    logic [31:0] model_regs [32];
    logic [31:0] exp_wr_addr [$];
    logic [31:0] exp_wr_data [$];
    logic [31:0] exp_ld_addr [$];
    logic [31:0] exp_ld_data [$];

    naive_core naive_core_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .ibus_addr_o  (ibus_addr),
        .ibus_read_o  (ibus_read),
        .ibus_rdata_i (ibus_rdata),
        .ibus_stall_i (ibus_stall),
        .dbus_addr_o  (dbus_addr),
        .dbus_read_o  (dbus_read),
        .dbus_write_o (dbus_write),
        .dbus_wdata_o (dbus_wdata),
        .dbus_rdata_i (dbus_rdata),
        .dbus_stall_i (dbus_stall)
    );

    // both memories answer in the same cycle
    assign ibus_rdata = imem[ibus_addr[11:2]];
    assign dbus_rdata = dmem[dbus_addr[13:2]];

    always #20 clk = ~clk;

    function automatic integer random_below(input integer n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'hc3a5_0f1e ^ (addr >> 7);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic build_program();
        integer n;
        integer body_end;
        integer kind;
        logic   after_branch;
        logic [5:0] fns [7];
        logic [5:0] iops [5];
        logic [4:0] rs;
        logic [4:0] rt;
        fns = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h2b};
        iops = '{OPC_ADDIU, OPC_SLTI, OPC_ANDI, OPC_ORI, OPC_XORI};
        for (int k = 0; k < 1024; k++) imem[k] = 32'h0; // nops past the end
        n = 0;
        for (int r = 1; r < 32; r++) begin
            imem[n] = enc_i(OPC_LUI, r, 0, random_below(65536));
            imem[n+1] = enc_i(OPC_ORI, r, r, random_below(65536));
            n = n + 2;
        end
        body_end = n + BODY_LEN;
        after_branch = 1'b0;
        while (n < body_end) begin
            kind = random_below(16);
            rs = random_below(7) + 1; // small pool so hazards are frequent
            rt = random_below(7) + 1;
            if (kind >= 14 && !after_branch && n + 4 < body_end) begin
                if (random_below(2) == 0) rt = rs;
                imem[n] = enc_i(random_below(2) ? OPC_BNE : OPC_BEQ, rt, rs,
                                random_below(3) + 1);
                after_branch = 1'b1;
            end else begin
                if (kind == 15 || kind == 14 || kind < 7)
                    imem[n] = enc_r(fns[random_below(7)], random_below(7) + 1, rs, rt);
                else if (kind < 10)
                    imem[n] = enc_i(iops[random_below(5)], rt, rs, random_below(65536));
                else if (kind == 10)
                    imem[n] = enc_i(OPC_LUI, rt, 0, random_below(65536));
                else if (kind < 13)
                    imem[n] = enc_i(OPC_LW, rt, 0, 16'h1000 + 4 * random_below(64));
                else
                    imem[n] = enc_i(OPC_SW, rt, 0, 16'h1000 + 4 * random_below(64));
                after_branch = 1'b0;
            end
            n = n + 1;
        end
        for (int r = 1; r < 32; r++) begin
            imem[n] = enc_i(OPC_SW, r, 0, SIG_BASE[15:0] + 4 * r);
            n = n + 1;
        end
        imem[n]   = enc_i(OPC_LUI, 1, 0, 16'h600d);
        imem[n+1] = enc_i(OPC_ORI, 1, 1, 16'hd0e5);
        imem[n+2] = enc_i(OPC_SW, 1, 0, MARKER[15:0]);
        imem[n+3] = enc_i(OPC_BEQ, 0, 0, 16'hffff); // spin here
        prog_len = n + 5;
    endtask

    // reference execution with one delay slot per branch
    task automatic run_model();
        logic [31:0] pc, npc, next_npc, w, se, ze, a, b, val, addr;
        logic [4:0]  dst;
        logic        done;
        integer      steps;
        for (int r = 0; r < 32; r++) model_regs[r] = 32'h0;
        pc = `MIPS_RESET_PC;
        npc = pc + 4;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 20000) begin
            w = imem[pc[11:2]];
            se = {{16{w[15]}}, w[15:0]};
            ze = {16'h0, w[15:0]};
            a = model_regs[w[25:21]];
            b = model_regs[w[20:16]];
            addr = a + se;
            next_npc = npc + 4;
            dst = 5'd0;
            val = 32'h0;
            case (w[31:26])
                OPC_SPECIAL: begin
                    dst = w[15:11];
                    case (w[5:0])
                        6'h21: val = a + b;
                        6'h23: val = a - b;
                        6'h24: val = a & b;
                        6'h25: val = a | b;
                        6'h26: val = a ^ b;
                        6'h2a: val = {31'h0, $signed(a) < $signed(b)};
                        6'h2b: val = {31'h0, a < b};
                        default: dst = 5'd0;
                    endcase
                end
                OPC_ADDIU: begin
                    dst = w[20:16];
                    val = a + se;
                end
                OPC_SLTI: begin
                    dst = w[20:16];
                    val = {31'h0, $signed(a) < $signed(se)};
                end
                OPC_ANDI: begin
                    dst = w[20:16];
                    val = a & ze;
                end
                OPC_ORI: begin
                    dst = w[20:16];
                    val = a | ze;
                end
                OPC_XORI: begin
                    dst = w[20:16];
                    val = a ^ ze;
                end
                OPC_LUI: begin
                    dst = w[20:16];
                    val = {w[15:0], 16'h0};
                end
                OPC_LW: begin
                    dst = w[20:16];
                    val = model_dmem[addr[13:2]];
                    exp_ld_addr.push_back(addr);
                    exp_ld_data.push_back(val);
                end
                OPC_SW: begin
                    exp_wr_addr.push_back(addr);
                    exp_wr_data.push_back(b);
                    model_dmem[addr[13:2]] = b;
                    if (addr == MARKER) done = 1'b1;
                end
                OPC_BEQ: if (a == b) next_npc = pc + 4 + (se << 2);
                OPC_BNE: if (a != b) next_npc = pc + 4 + (se << 2);
                default: ;
            endcase
            if (dst != 5'd0) model_regs[dst] = val;
            pc = npc;
            npc = next_npc;
            steps = steps + 1;
        end
    endtask

    initial begin
        seed = 32'hff72_4379;
        clk = 1'b0;
        rst_n = 1'b0;
        ibus_stall = 1'b0;
        dbus_stall = 1'b0;
        cycles = 0;
        wr_idx = 0;
        ld_idx = 0;
        first_seen = 1'b0;
        marker_seen = 1'b0;
        ibus_hold = 1'b0;
        dbus_hold = 1'b0;
        for (int k = 0; k < 4096; k++) begin
            dmem[k] = fill_word(k << 2);
            model_dmem[k] = fill_word(k << 2);
        end
        build_program();
        run_model();
        limit = 20 * prog_len + 10 * prog_len; // second term covers random stalls
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        wait (marker_seen);
        if (wr_idx == exp_wr_addr.size() && ld_idx == exp_ld_addr.size()) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_run("marker written before all expected accesses were seen");
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            ibus_stall <= (random_below(4) == 0);
            dbus_stall <= (random_below(4) == 0);
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles = cycles + 1;
            if (cycles > limit)
                fail_run("timeout: marker write did not appear within the cycle limit");
            if (!first_seen) begin
                check_value("ibus_read_o", ibus_read, 1'b1);
                check_value("ibus_addr_o", ibus_addr, `MIPS_RESET_PC);
                first_seen = 1'b1;
            end
            if (ibus_hold) check_value("ibus_addr_o", ibus_addr, prev_iaddr);
            if (dbus_hold) begin
                check_value("dbus_read_o", dbus_read, prev_dread);
                check_value("dbus_write_o", dbus_write, prev_dwrite);
                check_value("dbus_addr_o", dbus_addr, prev_daddr);
                if (prev_dwrite) check_value("dbus_wdata_o", dbus_wdata, prev_dwdata);
            end
            if (dbus_read && !dbus_stall) begin
                if (ld_idx >= exp_ld_addr.size())
                    fail_run("data bus read seen where no load was expected");
                check_value("dbus_addr_o", dbus_addr, exp_ld_addr[ld_idx]);
                check_value("dbus_rdata_i", dbus_rdata, exp_ld_data[ld_idx]);
                ld_idx = ld_idx + 1;
            end
            if (dbus_write && !dbus_stall) begin
                if (wr_idx >= exp_wr_addr.size())
                    fail_run("data bus write seen where no store was expected");
                check_value("dbus_addr_o", dbus_addr, exp_wr_addr[wr_idx]);
                check_value("dbus_wdata_o", dbus_wdata, exp_wr_data[wr_idx]);
                dmem[dbus_addr[13:2]] <= dbus_wdata;
                wr_idx = wr_idx + 1;
                if (dbus_addr == MARKER)
                    marker_seen = 1'b1;
            end
            ibus_hold   = ibus_read && ibus_stall;
            prev_iaddr  = ibus_addr;
            dbus_hold   = (dbus_read || dbus_write) && dbus_stall;
            prev_daddr  = dbus_addr;
            prev_dwdata = dbus_wdata;
            prev_dread  = dbus_read;
            prev_dwrite = dbus_write;
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/decode_unit.sv
rtl/hazard_unit.sv
rtl/execute_unit.sv
rtl/mem_wb_unit.sv
rtl/naive_core.sv
sim/naive_core_tb.sv
